// File: project.f
+incdir+include
hdl/fetch_pkg.sv
hdl/ibus_if.sv
hdl/fetch_ctrl_if.sv
hdl/branch_predictor.sv
hdl/fetch_unit.sv
hdl/fetch_stage.sv
hdl/fetch_top.sv
test/tb_clock.sv
test/fetch_chk.sv
test/fetch_tb.sv

// File: test/fetch_tb.sv
/* Directed tests of fetch_top with a word memory model and 0 to 3 random wait
   states. Expected instructions assume the byte order set in fetch_consts.svh */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_tb;
    localparam logic [31:0] ERR_ADDR = 32'h0000_6008;
    localparam int MAX_CYCLES = 4000;

    logic        CLK;
    logic        nRST;
    logic [31:0] imem_addr, imem_rdata, redirect_addr;
    logic        imem_ren, imem_busy, imem_error;
    logic        stall, flush, redirect, fetch_busy;
    logic [31:0] fetch_pc, ex_instr, ex_pc, ex_pc4, ex_pred_addr, ex_fault_addr;
    logic        ex_valid, ex_pred, ex_mal, ex_fault;
    logic [31:0] prog [logic [31:0]];
    logic [16:0] lfsr_state;
    logic [1:0]  wait_left = 2'd0;
    int          cycle_count;
    int          bad_req;

    tb_clock #(.PERIOD_NS(20)) u_clk (.CLK(CLK));

    fetch_top dut_i (.*);

    // Word reversal done here, independent of the DUT
    function automatic logic [31:0] bswap(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // Instruction the DUT should see for a given bus word
    function automatic logic [31:0] as_instr(input logic [31:0] w);
        return (`FETCH_BUS_LITTLE) ? bswap(w) : w;
    endfunction

    // Bus word at an address, NOP XOR address where no program sits
    function automatic logic [31:0] bus_word(input logic [31:0] a);
        if (prog.exists(a)) begin
            return prog[a];
        end
        return 32'h0000_0013 ^ a;
    endfunction

    // Store an instruction in bus byte order
    task automatic put_instr(input logic [31:0] a, input logic [31:0] insn);
        prog[a] = as_instr(insn);
    endtask

    // BEQ x0,x0 with a byte offset
    function automatic logic [31:0] enc_branch(input logic [12:0] off);
        return {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    // JAL x1 with a byte offset
    function automatic logic [31:0] enc_jal(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
    endfunction

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic take_waits(output logic [1:0] w);
        w = '0;
        repeat (2) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[0], lfsr_state[0]};
        end
    endtask

    // Memory responds combinationally once the wait count runs out
    assign imem_rdata = bus_word(imem_addr);
    assign imem_busy  = (wait_left != 2'd0);
    assign imem_error = (imem_addr == ERR_ADDR);

    always @(posedge CLK or negedge nRST) begin : mem_waits
        logic [1:0] w;
        if (!nRST) begin
            wait_left <= 2'd0;
        end else if (imem_ren) begin
            if (imem_addr[1:0] != 2'b00)
                bad_req++;
            if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin
                // Next read starts with fresh wait states
                take_waits(w);
                wait_left <= w;
            end
        end
    end

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: no result after %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $fatal(1);
        end
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail %s expected %h actual %h", name, exp, act);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // Next valid entry, sampled mid-cycle
    task automatic wait_entry();
        @(negedge CLK);
        while (!ex_valid)
            @(negedge CLK);
    endtask

    // Hold redirect and flush until the PC lands on the target
    task automatic jump_to(input logic [31:0] a);
        @(posedge CLK);
        redirect      <= 1'b1;
        flush         <= 1'b1;
        redirect_addr <= a;
        @(negedge CLK);
        while (fetch_pc !== a)
            @(negedge CLK);
    endtask

    task automatic release_ctrl();
        @(posedge CLK);
        redirect <= 1'b0;
        flush    <= 1'b0;
    endtask

    task automatic sequential_fetch();
        logic [31:0] a;
        for (int i = 0; i < 6; i++) begin
            a = `FETCH_RESET_PC + 32'(4 * i);
            wait_entry();
            check("sequential pc", a, ex_pc);
            check("sequential pc4", a + 32'd4, ex_pc4);
            check("sequential instr", as_instr(bus_word(a)), ex_instr);
            check("sequential pred", 32'd0, {31'd0, ex_pred});
            // Aligned PC, so the stage waits exactly as long as the bus
            check("sequential busy", {31'd0, imem_busy}, {31'd0, fetch_busy});
        end
    endtask

    task automatic stall_and_flush();
        logic [31:0] pc_s, instr_s, held_pc;
        wait_entry();
        // Stall right after an edge that takes a completed fetch
        while (imem_busy)
            @(negedge CLK);
        @(posedge CLK);
        stall <= 1'b1;
        @(negedge CLK);
        pc_s    = ex_pc;
        instr_s = ex_instr;
        held_pc = fetch_pc;
        for (int i = 0; i < 6; i++) begin
            // Flush during the last cycles must be ignored
            if (i == 3) begin
                @(posedge CLK);
                flush <= 1'b1;
            end
            @(negedge CLK);
            check("stall valid", 32'd1, {31'd0, ex_valid});
            check("stall ex_pc", pc_s, ex_pc);
            check("stall ex_instr", instr_s, ex_instr);
            check("stall fetch_pc", held_pc, fetch_pc);
        end
        @(posedge CLK);
        stall <= 1'b0;
        // First edge without stall takes the flush
        @(posedge CLK);
        flush <= 1'b0;
        @(negedge CLK);
        check("flush valid", 32'd0, {31'd0, ex_valid});
    endtask

    task automatic static_prediction();
        jump_to(32'h0000_2010);
        release_ctrl();
        wait_entry();
        check("backward pc", 32'h0000_2010, ex_pc);
        check("backward pred", 32'd1, {31'd0, ex_pred});
        check("backward target", 32'h0000_2000, ex_pred_addr);
        wait_entry();
        check("backward next", 32'h0000_2000, ex_pc);
        jump_to(32'h0000_3000);
        release_ctrl();
        wait_entry();
        check("forward pc", 32'h0000_3000, ex_pc);
        check("forward pred", 32'd0, {31'd0, ex_pred});
        wait_entry();
        check("forward next", 32'h0000_3004, ex_pc);
        check("jalr pred", 32'd0, {31'd0, ex_pred});
        wait_entry();
        check("jalr next", 32'h0000_3008, ex_pc);
        check("jal pred", 32'd1, {31'd0, ex_pred});
        check("jal target", 32'h0000_3108, ex_pred_addr);
        wait_entry();
        check("jal next", 32'h0000_3108, ex_pc);
    endtask

    task automatic redirect_over_prediction();
        jump_to(32'h0000_2010);
        @(posedge CLK);
        redirect_addr <= 32'h0000_5000;
        // Branch at 0x2010 predicts 0x2000, the held redirect has to win
        @(negedge CLK);
        while (fetch_pc === 32'h0000_2010)
            @(negedge CLK);
        check("redirect next pc", 32'h0000_5000, fetch_pc);
        release_ctrl();
        wait_entry();
        check("redirect pc", 32'h0000_5000, ex_pc);
        check("redirect instr", as_instr(bus_word(32'h0000_5000)), ex_instr);
    endtask

    task automatic byte_order();
        jump_to(32'h0000_4000);
        release_ctrl();
        wait_entry();
        check("byte order instr", bswap(prog[32'h0000_4000]), ex_instr);
    endtask

    task automatic fault_entries();
        jump_to(ERR_ADDR);
        release_ctrl();
        wait_entry();
        check("bus error fault", 32'd1, {31'd0, ex_fault});
        check("bus error instr", 32'd0, ex_instr);
        check("bus error addr", ERR_ADDR, ex_fault_addr);
        // Misaligned PC stays misaligned after each +4
        jump_to(32'h0000_7002);
        release_ctrl();
        wait_entry();
        check("misaligned mal", 32'd1, {31'd0, ex_mal});
        check("misaligned instr", 32'd0, ex_instr);
        check("misaligned addr", 32'h0000_7002, ex_fault_addr);
        check("misaligned busy", 32'd0, {31'd0, fetch_busy});
        check("misaligned requests", 32'd0, 32'(bad_req));
    endtask

    initial begin
        nRST          = 1'b0;
        stall         = 1'b0;
        flush         = 1'b0;
        redirect      = 1'b0;
        redirect_addr = '0;
        lfsr_state    = 17'd99605;
        cycle_count   = 0;
        bad_req       = 0;
        // Test programs
        put_instr(32'h0000_2010, enc_branch(-13'sd16));
        put_instr(32'h0000_3000, enc_branch(13'd16));
        put_instr(32'h0000_3004, 32'h0000_8067);
        put_instr(32'h0000_3008, enc_jal(21'h100));
        prog[32'h0000_4000] = 32'h9356_3412;
        repeat (16) @(posedge CLK);
        nRST <= 1'b1;
        sequential_fetch();
        stall_and_flush();
        static_prediction();
        redirect_over_prediction();
        byte_order();
        fault_entries();
        $display("Regression passed");
        $finish;
    end

endmodule

// File: test/fetch_chk.sv
/* Bus and fetch/execute register assertions, bound into every fetch_stage.
   Bus checks only look at cycles with ren high */
`timescale 1ns/1ps

module fetch_chk (
    input logic        CLK,
    input logic        nRST,
    input logic        ren,
    input logic        busy,
    input logic        pending,
    input logic [31:0] addr,
    input logic        ex_valid,
    input logic        ex_mal,
    input logic        ex_fault,
    input logic [31:0] ex_instr
);
    // Address holds while the fetch unit still waits on the read
    a_addr_steady: assert property (@(posedge CLK) disable iff (!nRST)
        (pending && ren) |-> $stable(addr))
        else $error("bus address moved while the read was busy");

    // Misaligned address never reaches the bus
    a_no_mal_req: assert property (@(posedge CLK) disable iff (!nRST)
        (addr[1:0] != 2'b00) |-> !ren)
        else $error("bus request made on a misaligned PC");

    // Register stays empty in reset
    a_reset_empty: assert property (@(posedge CLK) !nRST |-> !ex_valid)
        else $error("fetch/execute register valid during reset");

    // Faulting entries carry no instruction
    a_squash: assert property (@(posedge CLK) disable iff (!nRST)
        (ex_mal || ex_fault) |-> (ex_instr == 32'h0))
        else $error("faulting entry carries a nonzero instruction");

endmodule

bind fetch_stage fetch_chk u_chk (
    .CLK(CLK),
    .nRST(nRST),
    .ren(bus.ren),
    .busy(bus.busy),
    .pending(u_fetch.req_pending),
    .addr(bus.addr),
    .ex_valid(ex_reg.valid),
    .ex_mal(ex_reg.mal_insn),
    .ex_fault(ex_reg.fault_insn),
    .ex_instr(ex_reg.instr)
);

// File: test/tb_clock.sv
/* Free-running testbench clock, starts low */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic CLK
);
    initial begin
        CLK = 1'b0;
    end

    // Half period per phase
    always #(PERIOD_NS / 2) CLK = ~CLK;

endmodule

// File: hdl/fetch_top.sv
/* Fetch stage with flat ports for the instruction memory, the pipeline
   controls and the execute side. No logic of its own */
`timescale 1ns/1ps

module fetch_top (
    input  logic             CLK,
    input  logic             nRST,

    // Instruction memory
    output fetch_pkg::word_t imem_addr,
    output logic             imem_ren,
    input  fetch_pkg::word_t imem_rdata,
    input  logic             imem_busy,
    input  logic             imem_error,

    // Pipeline controls
    input  logic             stall,
    input  logic             flush,
    input  logic             redirect,
    input  fetch_pkg::word_t redirect_addr,

    // Status
    output logic             fetch_busy,
    output fetch_pkg::word_t fetch_pc,

    // Execute side
    output logic             ex_valid,
    output fetch_pkg::word_t ex_instr,
    output fetch_pkg::word_t ex_pc,
    output fetch_pkg::word_t ex_pc4,
    output logic             ex_pred,
    output fetch_pkg::word_t ex_pred_addr,
    output logic             ex_mal,
    output logic             ex_fault,
    output fetch_pkg::word_t ex_fault_addr
);
    import fetch_pkg::*;

    fetch_ex_t ex_reg;

    ibus_if       bus_if ();
    fetch_ctrl_if ctrl_if ();

    // Memory side of the bus
    assign imem_addr     = bus_if.addr;
    assign imem_ren      = bus_if.ren;
    assign bus_if.rdata  = imem_rdata;
    assign bus_if.busy   = imem_busy;
    assign bus_if.error  = imem_error;

    // Controls in, status out
    assign ctrl_if.stall         = stall;
    assign ctrl_if.flush         = flush;
    assign ctrl_if.redirect      = redirect;
    assign ctrl_if.redirect_addr = redirect_addr;
    assign fetch_busy            = ctrl_if.busy_f;
    assign fetch_pc              = ctrl_if.pc_f;

    fetch_stage u_stage (
        .CLK,
        .nRST,
        .ctrl(ctrl_if.stage),
        .bus(bus_if.cpu),
        .ex_reg
    );

    // Unpack the fetch/execute register
    assign ex_valid      = ex_reg.valid;
    assign ex_instr      = ex_reg.instr;
    assign ex_pc         = ex_reg.pc;
    assign ex_pc4        = ex_reg.pc4;
    assign ex_pred       = ex_reg.prediction;
    assign ex_pred_addr  = ex_reg.predicted_address;
    assign ex_mal        = ex_reg.mal_insn;
    assign ex_fault      = ex_reg.fault_insn;
    assign ex_fault_addr = ex_reg.fault_addr;

endmodule

// File: hdl/fetch_stage.sv
/* PC register, next-PC select and fetch/execute register. A fetch completing
   in a redirect cycle is still recorded, the caller must flush it */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_stage (
    input  logic                CLK,
    input  logic                nRST,
    fetch_ctrl_if.stage         ctrl,
    ibus_if.cpu                 bus,
    output fetch_pkg::fetch_ex_t ex_reg
);
    import fetch_pkg::*;

    word_t     pc;
    word_t     pc4;
    word_t     npc;
    word_t     instr_f;
    word_t     target_addr;
    logic      ireq;
    logic      insn_ready;
    logic      insn_fault;
    logic      mal_addr;
    logic      predict_taken;
    logic      use_pred;
    logic      pc_en;
    logic      squash;
    fetch_ex_t entry;

    // Always fetching, the request holds through a stall
    assign ireq = 1'b1;

    fetch_unit u_fetch (
        .CLK,
        .nRST,
        .ireq,
        .pc,
        .insn_ready,
        .insn_fault,
        .mal_addr,
        .insn_out(instr_f),
        .bus
    );

    branch_predictor u_pred (
        .instr(instr_f),
        .pc,
        .predict_taken,
        .target_addr
    );

    // No compressed instructions
    assign pc4 = pc + 32'd4;

    // Read data is only meaningful on a clean completed fetch
    assign use_pred = predict_taken && insn_ready && !insn_fault && !mal_addr;

    // Redirect beats prediction beats PC+4
    assign npc = ctrl.redirect ? ctrl.redirect_addr :
                 use_pred      ? target_addr       :
                                 pc4;

    // Advance once the current fetch is done and execute can take it
    assign pc_en = insn_ready && !ctrl.stall;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc <= `FETCH_RESET_PC;
        end else if (pc_en) begin
            pc <= npc;
        end
    end

    // Faulting entries stay valid so execute can raise the exception
    assign squash = mal_addr || insn_fault;

    always_comb begin
        entry                   = '0;
        entry.valid             = 1'b1;
        entry.instr             = squash ? '0 : instr_f;
        entry.pc                = pc;
        entry.pc4               = pc4;
        entry.prediction        = use_pred;
        entry.predicted_address = target_addr;
        entry.mal_insn          = mal_addr;
        entry.fault_insn        = insn_fault;
        // Word fetches, so the faulting address is the PC itself
        entry.fault_addr        = pc;
    end

    // Stall holds everything, flush under stall is dropped
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ex_reg <= '0;
        end else if (!ctrl.stall) begin
            if (ctrl.flush || !insn_ready) begin
                // Bubble
                ex_reg <= '0;
            end else begin
                ex_reg <= entry;
            end
        end
    end

    // Status for the hazard logic
    assign ctrl.busy_f = !insn_ready;
    assign ctrl.pc_f   = pc;

endmodule

// File: hdl/fetch_unit.sv
/* Issues one word read per PC over ibus_if, no request on a misaligned PC.
   Byte swap of read data is chosen by `FETCH_BUS_LITTLE at compile time */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_unit (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             ireq,
    input  fetch_pkg::word_t pc,
    output logic             insn_ready,
    output logic             insn_fault,
    output logic             mal_addr,
    output fetch_pkg::word_t insn_out,
    ibus_if.cpu              bus
);
    import fetch_pkg::*;

    word_t rdata_swapped;
    logic  read_done;
    logic  req_pending;

    // Only 4-byte alignment, no compressed instructions
    assign mal_addr = |pc[1:0];

    // Request stays up as long as the PC is aligned and a fetch is wanted
    assign bus.ren  = ireq && !mal_addr;
    assign bus.addr = pc;

    // Bus read finished this cycle
    assign read_done = bus.ren && !bus.busy;

    // A misaligned PC completes at once with no bus traffic
    assign insn_ready = mal_addr || read_done;
    assign insn_fault = read_done && bus.error;

    // Reverse byte lanes of the read word
    for (genvar i = 0; i < `FETCH_XLEN / 8; i++) begin : g_byte
        assign rdata_swapped[8*i +: 8] = bus.rdata[`FETCH_XLEN-8-8*i +: 8];
    end

    // Pick byte order for this build
    if (`FETCH_BUS_LITTLE) begin : g_little
        assign insn_out = rdata_swapped;
    end else begin : g_big
        assign insn_out = bus.rdata;
    end

    // Read still outstanding at the last edge
    // Address must not move while this is set and ren is high
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            req_pending <= 1'b0;
        end else begin
            req_pending <= bus.ren && bus.busy;
        end
    end

endmodule

// File: hdl/branch_predictor.sv
/* Static predictor, backward branches and JAL taken, everything else not taken.
   Purely combinational, JALR targets are never predicted */
`timescale 1ns/1ps

module branch_predictor (
    input  fetch_pkg::word_t instr,
    input  fetch_pkg::word_t pc,
    output logic             predict_taken,
    output fetch_pkg::word_t target_addr
);
    import fetch_pkg::*;

    sbtype_t instr_sb;
    ujtype_t instr_uj;
    word_t   imm_sb;
    word_t   imm_uj;

    // Same bits seen through both formats
    assign instr_sb = sbtype_t'(instr);
    assign instr_uj = ujtype_t'(instr);

    // B-type immediate, bit 0 always zero
    assign imm_sb = {{19{instr_sb.imm12}}, instr_sb.imm12, instr_sb.imm11,
                     instr_sb.imm10_05, instr_sb.imm04_01, 1'b0};

    // J-type immediate, bit 0 always zero
    assign imm_uj = {{11{instr_uj.imm20}}, instr_uj.imm20, instr_uj.imm19_12,
                     instr_uj.imm11, instr_uj.imm10_01, 1'b0};

    always_comb begin
        case (instr_sb.opcode)
            BRANCH: begin
                // Negative offset means a loop back edge
                predict_taken = instr_sb.imm12;
                target_addr   = pc + imm_sb;
            end
            JAL: begin
                // Unconditional and PC-relative
                predict_taken = 1'b1;
                target_addr   = pc + imm_uj;
            end
            default: begin
                // JALR needs rs1, so no target here
                predict_taken = 1'b0;
                target_addr   = pc + imm_sb;
            end
        endcase
    end

endmodule

// File: hdl/fetch_ctrl_if.sv
/* Pipeline controls into the fetch stage and its status back out.
   A redirect only lands on an edge where the PC advances */
`timescale 1ns/1ps

interface fetch_ctrl_if;
    import fetch_pkg::*;

    // Back-pressure from execute, freezes PC and fetch/execute register
    logic  stall;
    // Loads a bubble unless stalled
    logic  flush;
    // Overrides any prediction
    logic  redirect;
    word_t redirect_addr;

    // Fetch still waiting on the bus
    logic  busy_f;
    // Current PC
    word_t pc_f;

    // Driver of the controls
    modport ctrl (
        output stall,
        output flush,
        output redirect,
        output redirect_addr,
        input  busy_f,
        input  pc_f
    );

    // Fetch stage end
    modport stage (
        input  stall,
        input  flush,
        input  redirect,
        input  redirect_addr,
        output busy_f,
        output pc_f
    );

endinterface

// File: hdl/ibus_if.sv
/* Level-based instruction read bus. addr must hold while ren is high
   and a read completes in the cycle busy is low */
`timescale 1ns/1ps

interface ibus_if;
    import fetch_pkg::*;

    // Request side
    word_t addr;
    logic  ren;

    // Response side
    // rdata and error only count while busy is low
    word_t rdata;
    logic  busy;
    logic  error;

    // Fetch unit end
    modport cpu (
        output addr,
        output ren,
        input  rdata,
        input  busy,
        input  error
    );

    // Memory end
    modport mem (
        input  addr,
        input  ren,
        output rdata,
        output busy,
        output error
    );

endinterface

// File: hdl/fetch_pkg.sv
/* Shared types of the fetch stage. Only the RV32I base opcodes are listed,
   compressed formats are not covered */
`include "fetch_consts.svh"

package fetch_pkg;

    // One data path word
    typedef logic [`FETCH_XLEN-1:0] word_t;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        LUI     = 7'b0110111,
        AUIPC   = 7'b0010111,
        JAL     = 7'b1101111,
        JALR    = 7'b1100111,
        BRANCH  = 7'b1100011,
        LOAD    = 7'b0000011,
        STORE   = 7'b0100011,
        IMMED   = 7'b0010011,
        REGREG  = 7'b0110011,
        MISCMEM = 7'b0001111,
        SYSTEM  = 7'b1110011
    } opcode_t;

    // Conditional branch layout
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_05;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm04_01;
        logic       imm11;
        opcode_t    opcode;
    } sbtype_t;

    // JAL layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_01;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_t    opcode;
    } ujtype_t;

    // Fetch/execute pipeline register
    typedef struct packed {
        logic  valid;
        word_t instr;
        word_t pc;
        word_t pc4;
        logic  prediction;
        word_t predicted_address;
        logic  mal_insn;
        logic  fault_insn;
        word_t fault_addr;
    } fetch_ex_t;

endpackage

// File: include/fetch_consts.svh
/* Compile-time constants of the fetch stage. The bus byte order is fixed per build
   and the bus always returns whole 32-bit words from word-aligned addresses */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Address of the first fetch after reset
`define FETCH_RESET_PC 32'h0000_1000

// Width of the data path and of one instruction
`define FETCH_XLEN 32

// Bus byte order
// 1 means a little-endian bus, so read data is byte swapped
// 0 means a big-endian bus, read data passes as is
`define FETCH_BUS_LITTLE 1'b1

`endif
